/* flist.f */
hw/soc_pkg.sv
hw/tick_gen.sv
hw/debounce.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/uart_loader.sv
hw/soc_ram.sv
hw/top.sv
verif/tb_top.sv

/* verif/tb_top.sv */
// testbench for the SoC top; a uart host model loads, reads back and queries the loader
`timescale 1ns/1ps
`default_nettype none

module tb_top
   import soc_pkg::*;
();

   localparam int CLKS_PER_BIT = BIT_US * CLKS_PER_US;   // 80 clocks per uart bit
   localparam int WAIT_LIMIT   = 200 * CLKS_PER_US;      // 200 us per wait

   logic clk;
   logic arst_n;
   logic key;
   led_t led_n;
   logic uart_rx;
   logic uart_tx;

   word_t       mirror [NUM_WORDS_IMEM];   // host copy of program memory
   logic [15:0] wr_addr [8];               // full 16-bit host addresses
   int          wr_done;                   // completed W commands
   int          fail_count;
   int unsigned seed_init;

   top uut (
      .clk     (clk),
      .arst_n  (arst_n),
      .key     (key),
      .led_n   (led_n),
      .uart_rx (uart_rx),
      .uart_tx (uart_tx)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 10 MHz
   end

   // ====================
   // helpers
   // ====================
   task automatic stop_with_failure();
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input string test_name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         fail_count++;
         $display("FAIL %s expected %0h actual %0h", test_name, expected, actual);
         stop_with_failure();
      end
   endtask

   // drives one 8N1 frame, called and returning 1 ns after a rising edge
   task automatic send_byte(input byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         uart_rx = frame[i];
         repeat (CLKS_PER_BIT) @(posedge clk);
         #1;
      end
   endtask

   // samples uart_tx on falling clk edges, returns at mid stop bit
   task automatic receive_byte(output byte_t b);
      int   waited;
      logic found;
      found = 1'b0;
      b     = '0;
      for (waited = 0; waited < WAIT_LIMIT && !found; waited++) begin
         @(negedge clk);
         if (uart_tx === 1'b0) found = 1'b1;
      end
      if (!found) begin
         $display("timeout: no start bit seen on uart_tx within 200 us");
         stop_with_failure();
      end
      repeat (CLKS_PER_BIT / 2) @(negedge clk);   // mid start bit
      if (uart_tx !== 1'b0) begin
         $display("start bit on uart_tx did not stay low until mid bit");
         stop_with_failure();
      end
      for (int i = 0; i < 8; i++) begin
         repeat (CLKS_PER_BIT) @(negedge clk);
         b[i] = uart_tx;                          // lsb first
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      if (uart_tx !== 1'b1) begin
         $display("stop bit on uart_tx was low");
         stop_with_failure();
      end
   endtask

   // sends n_tx bytes and collects n_rx reply bytes, first byte ends in [31:24] for 4
   task automatic transact(input byte_t msg [7], input int n_tx, input int n_rx,
                           output word_t reply);
      byte_t b;
      reply = '0;
      @(posedge clk);   // line driven 1 ns after a rising edge
      #1;
      for (int i = 0; i < n_tx - 1; i++) send_byte(msg[i]);
      // reply can start before the last stop bit ends
      fork
         send_byte(msg[n_tx-1]);
         receive_byte(b);
      join
      reply = {reply[23:0], b};
      for (int i = 1; i < n_rx; i++) begin
         receive_byte(b);
         reply = {reply[23:0], b};
      end
   endtask

   task automatic write_word(input logic [15:0] addr, input word_t data, output byte_t rsp);
      byte_t msg [7];
      word_t reply;
      msg = '{CMD_WRITE, addr[15:8], addr[7:0], data[31:24], data[23:16], data[15:8],
              data[7:0]};
      transact(msg, 7, 1, reply);
      rsp = reply[7:0];
   endtask

   task automatic read_word(input logic [15:0] addr, output word_t data);
      byte_t msg [7];
      msg = '{CMD_READ, addr[15:8], addr[7:0], 8'h00, 8'h00, 8'h00, 8'h00};
      transact(msg, 3, 4, data);   // msb arrives first
   endtask

   task automatic send_single(input byte_t b0, input byte_t b1, input int n_tx,
                              output byte_t rsp);
      byte_t msg [7];
      word_t reply;
      msg = '{b0, b1, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
      transact(msg, n_tx, 1, reply);
      rsp = reply[7:0];
   endtask

   task automatic check_status(input string test_name, input logic key_exp);
      byte_t rsp;
      byte_t expected;
      expected = {4'(wr_done), 3'b000, key_exp};   // count nibble, key in bit 0
      send_single(CMD_STATUS, 8'h00, 1, rsp);
      check_value(test_name, expected, rsp);
   endtask

   task automatic drive_key(input logic level);
      @(posedge clk);
      #1 key = level;
   endtask

   // ====================
   // stimulus
   // ====================
   initial begin
      word_t got;
      word_t data;
      byte_t rsp;
      byte_t led_v;
      arst_n     = 1'b0;
      key        = 1'b0;
      uart_rx    = 1'b1;   // idle line
      wr_done    = 0;
      fail_count = 0;
      seed_init  = $urandom(32'h8eb0);
      repeat (3) @(posedge clk);
      #1 arst_n = 1'b1;

      // leds dark and tx idle out of reset
      @(negedge clk);
      check_value("reset_led", 2'b11, led_n);
      for (int i = 0; i < 20 * CLKS_PER_US; i++) begin
         @(negedge clk);
         check_value("reset_tx_idle", 1'b1, uart_tx);
      end

      // eight writes, even ones above 1023 to hit aliasing
      @(posedge clk);
      #1;
      for (int i = 0; i < 8; i++) begin
         wr_addr[i] = 16'($urandom_range(0, 16'hffff));
         if (i % 2 == 0) wr_addr[i][10] = 1'b1;
         data = $urandom;
         mirror[wr_addr[i][IMEM_AW-1:0]] = data;   // upper bits drop
         write_word(wr_addr[i], data, rsp);
         wr_done++;
         check_value("write_ack", RSP_ACK, rsp);
      end

      for (int i = 0; i < 8; i++) begin
         read_word(wr_addr[i], got);
         check_value("read_back", mirror[wr_addr[i][IMEM_AW-1:0]], got);
      end
      read_word({6'h00, wr_addr[0][IMEM_AW-1:0]}, got);   // same word, low bits only
      check_value("read_alias", mirror[wr_addr[0][IMEM_AW-1:0]], got);

      // led register
      led_v = 8'($urandom);
      send_single(CMD_LED, led_v, 2, rsp);
      check_value("led_ack", RSP_ACK, rsp);
      check_value("led_value", led_v[1:0], led_n);

      // status with key released, held, released, then a short glitch
      check_status("status_key_low", 1'b0);
      drive_key(1'b1);
      repeat (150 * CLKS_PER_US) @(posedge clk);
      check_status("status_key_high", 1'b1);
      drive_key(1'b0);
      repeat (150 * CLKS_PER_US) @(posedge clk);
      check_status("status_key_release", 1'b0);
      // pulse covers the point where the loader takes key_clean for the reply
      fork
         check_status("status_key_pulse", 1'b0);
         begin
            repeat (70 * CLKS_PER_US) @(posedge clk);
            drive_key(1'b1);
            repeat (10 * CLKS_PER_US) @(posedge clk);   // too short to pass the filter
            drive_key(1'b0);
         end
      join

      // unknown command, loader must recover
      send_single(8'hA5, 8'h00, 1, rsp);
      check_value("unknown_nak", RSP_NAK, rsp);
      read_word(wr_addr[3], got);
      check_value("read_after_nak", mirror[wr_addr[3][IMEM_AW-1:0]], got);

      if (fail_count == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         stop_with_failure();
      end
   end

endmodule: tb_top

`default_nettype wire

/* hw/top.sv */
// board-level SoC top; ties tick, key, uart, loader and program memory to the pins
`timescale 1ns/1ps
`default_nettype none

module top
   import soc_pkg::*;
(
   input  logic clk,        // board oscillator
   input  logic arst_n,     // external reset, active low
   input  logic key,        // user button, active high
   output led_t led_n,      // onboard leds, active low
   input  logic uart_rx,    // -\ host uart
   output logic uart_tx     // -/
);

   // ====================
   // ticks and key
   // ====================
   logic tick_1us;
   logic tick_15us;
   logic key_clean;

   tick_gen u_tick (
      .clk       (clk),          //i
      .arst_n    (arst_n),       //i
      .tick_1us  (tick_1us),     //o
      .tick_15us (tick_15us)     //o
   );

   debounce u_debounce (
      .clk       (clk),          //i
      .arst_n    (arst_n),       //i
      .tick_15us (tick_15us),    //i
      .key       (key),          //i
      .key_clean (key_clean)     //o
   );

   // ====================
   // uart and loader
   // ====================
   logic      rx_valid;
   byte_t     rx_byte;
   logic      tx_start;
   byte_t     tx_byte;
   logic      tx_busy;
   imem_req_t imem_req;
   word_t     rdat;
   led_t      led_off;

   uart_rx u_uart_rx (
      .clk      (clk),   .arst_n  (arst_n),   .tick_1us (tick_1us),
      .uart_rx  (uart_rx),                    //i pin
      .rx_valid (rx_valid), .rx_byte (rx_byte) //o
   );

   uart_tx u_uart_tx (
      .clk      (clk),   .arst_n  (arst_n),   .tick_1us (tick_1us),
      .tx_start (tx_start), .tx_byte (tx_byte), //i
      .tx_busy  (tx_busy),                      //o
      .uart_tx  (uart_tx)                       //o pin
   );

   uart_loader u_loader (
      .clk      (clk),      .arst_n   (arst_n),
      .rx_valid (rx_valid), .rx_byte  (rx_byte),
      .tx_busy  (tx_busy),  .tx_start (tx_start), .tx_byte (tx_byte),
      .imem_req (imem_req), .rdat     (rdat),       // program memory port
      .key_clean(key_clean),
      .led_off  (led_off)
   );

   soc_ram u_imem (
      .clk      (clk),      //i
      .imem_req (imem_req), //i
      .rdat     (rdat)      //o
   );

   assign led_n = led_off;  // 1 = off, pins are active low

endmodule: top

`default_nettype wire

/* hw/soc_ram.sv */
// single-port program memory, write or registered read driven by the loader request
`timescale 1ns/1ps
`default_nettype none

module soc_ram
   import soc_pkg::*;
(
   input  logic      clk,
   input  imem_req_t imem_req,
   output word_t     rdat       // valid one clk after re
);

   // ====================
   // storage
   // ====================
   word_t mem [NUM_WORDS_IMEM];   // maps to block ram

   // write port
   always_ff @(posedge clk) begin
      if (imem_req.we) begin
         mem[imem_req.addr] <= imem_req.wdat;
      end
   end

   // read port, holds last value when re low
   always_ff @(posedge clk) begin
      if (imem_req.re) begin
         rdat <= mem[imem_req.addr];
      end
   end

endmodule: soc_ram

`default_nettype wire

/* hw/uart_loader.sv */
// uart command parser; reloads program memory, owns the led register and sends replies
`timescale 1ns/1ps
`default_nettype none

module uart_loader
   import soc_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  logic      rx_valid,
   input  byte_t     rx_byte,
   input  logic      tx_busy,
   output logic      tx_start,
   output byte_t     tx_byte,
   output imem_req_t imem_req,
   input  word_t     rdat,
   input  logic      key_clean,
   output led_t      led_off     // 1 = led dark
);

   loader_state_e state;
   logic          is_wr;       // W vs R sharing the address states
   logic [1:0]    byte_cnt;    // write data bytes received
   logic [3:0]    wr_cnt;      // completed W commands, low nibble
   logic [2:0]    rsp_cnt;     // reply bytes still to send
   logic          we_q;
   logic          re_q;
   imem_addr_t    addr_q;
   word_t         wdat_q;
   word_t         rsp_buf;     // next byte in [31:24]

   logic          rsp_load;    // reply ready this cycle
   word_t         rsp_word;
   logic [2:0]    rsp_len;
   logic          send;        // hand one byte to uart_tx

   assign imem_req = '{we: we_q, re: re_q, addr: addr_q, wdat: wdat_q};
   assign send     = (state == REPLY) && (rsp_cnt != '0) && !tx_busy && !tx_start;

   // ====================
   // reply selection
   // ====================
   always_comb begin
      rsp_load = 1'b0;
      rsp_word = {RSP_ACK, 24'h0};
      rsp_len  = 3'd1;
      case (state)
         IDLE: if (rx_valid) begin
            case (rx_byte)
               CMD_WRITE, CMD_READ, CMD_LED: ;       // arguments follow
               CMD_STATUS: begin
                  rsp_load = 1'b1;
                  rsp_word = {wr_cnt, 3'b000, key_clean, 24'h0};
               end
               default: begin
                  rsp_load = 1'b1;
                  rsp_word = {RSP_NAK, 24'h0};
               end
            endcase
         end
         DATA:    rsp_load = rx_valid && (byte_cnt == 2'd3);
         LED_VAL: rsp_load = rx_valid;
         MEM_RD: if (!re_q) begin                     // rdat valid now
            rsp_load = 1'b1;
            rsp_word = rdat;
            rsp_len  = 3'd4;
         end
         default: ;
      endcase
   end

   // ====================
   // control FSM
   // ====================
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= IDLE;
         is_wr    <= 1'b0;
         byte_cnt <= '0;
         wr_cnt   <= '0;
         rsp_cnt  <= '0;
         we_q     <= 1'b0;
         re_q     <= 1'b0;
         tx_start <= 1'b0;
         led_off  <= '1;
      end else begin
         we_q     <= 1'b0;   // single-cycle strobes
         re_q     <= 1'b0;
         tx_start <= 1'b0;
         case (state)
            IDLE: if (rx_valid) begin
               is_wr <= (rx_byte == CMD_WRITE);
               if (rx_byte == CMD_WRITE || rx_byte == CMD_READ) state <= ADDR_HI;
               else if (rx_byte == CMD_LED)                      state <= LED_VAL;
            end
            ADDR_HI: if (rx_valid) state <= ADDR_LO;
            ADDR_LO: if (rx_valid) begin
               byte_cnt <= '0;
               if (is_wr) begin
                  state <= DATA;
               end else begin
                  re_q  <= 1'b1;
                  state <= MEM_RD;
               end
            end
            DATA: if (rx_valid) begin
               byte_cnt <= byte_cnt + 1'b1;
               if (byte_cnt == 2'd3) begin
                  we_q   <= 1'b1;              // write in cycle after d0
                  wr_cnt <= wr_cnt + 1'b1;
               end
            end
            LED_VAL: if (rx_valid) led_off <= rx_byte[1:0];
            REPLY: begin
               if (send) begin
                  tx_start <= 1'b1;
                  rsp_cnt  <= rsp_cnt - 1'b1;
               end else if (rsp_cnt == '0 && !tx_busy && !tx_start) begin
                  state <= IDLE;               // last stop bit is out
               end
            end
            default: ;                         // MEM_RD waits on rsp_load
         endcase
         if (rsp_load) begin
            state   <= REPLY;
            rsp_cnt <= rsp_len;
         end
      end
   end

   // ====================
   // payload registers
   // ====================
   always_ff @(posedge clk) begin
      if (rx_valid && (state == ADDR_HI || state == ADDR_LO))
         addr_q <= imem_addr_t'({addr_q, rx_byte});  // upper bits fall off
      if (rx_valid && state == DATA)
         wdat_q <= {wdat_q[23:0], rx_byte};          // msb first
      if (rsp_load) begin
         rsp_buf <= rsp_word;
      end else if (send) begin
         tx_byte <= rsp_buf[31:24];
         rsp_buf <= {rsp_buf[23:0], 8'h00};
      end
   end

   a_no_we_with_re: assert property (@(posedge clk) disable iff (!arst_n)
      !(imem_req.we && imem_req.re));

endmodule: uart_loader

`default_nettype wire

/* hw/uart_tx.sv */
// 8N1 uart transmitter; takes a byte on tx_start, busy until stop bit ends
`timescale 1ns/1ps
`default_nettype none

module uart_tx
   import soc_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   input  logic  tick_1us,
   input  logic  tx_start,    // one clk strobe, only when idle
   input  byte_t tx_byte,
   output logic  tx_busy,
   output logic  uart_tx      // serial line, idle high
);

   typedef logic [$clog2(BIT_US)-1:0] bit_tmr_t;

   logic [9:0] frame;     // {stop, data, start}, shifted out lsb first
   bit_tmr_t   bit_tmr;   // remaining us ticks of current bit
   logic [3:0] bit_cnt;   // bits already put on the line

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         frame   <= '1;
         bit_tmr <= '0;
         bit_cnt <= '0;
         tx_busy <= 1'b0;
         uart_tx <= 1'b1;
      end else if (tx_start) begin
         frame   <= {1'b1, tx_byte, 1'b0};
         bit_tmr <= '0;                      // first bit goes out at next tick
         bit_cnt <= '0;
         tx_busy <= 1'b1;
      end else if (tx_busy && tick_1us) begin
         if (bit_tmr != '0) begin
            bit_tmr <= bit_tmr - 1'b1;
         end else if (bit_cnt == 4'd10) begin
            tx_busy <= 1'b0;                 // stop bit done
         end else begin
            uart_tx <= frame[0];
            frame   <= {1'b1, frame[9:1]};
            bit_cnt <= bit_cnt + 1'b1;
            bit_tmr <= bit_tmr_t'(BIT_US - 1);
         end
      end
   end

   // loader must wait for the previous frame
   a_no_start_when_busy: assert property (@(posedge clk) disable iff (!arst_n)
      tx_start |-> !tx_busy);

endmodule: uart_tx

`default_nettype wire

/* hw/uart_rx.sv */
// 8N1 uart receiver paced by the 1us tick; pulses rx_valid mid stop bit
`timescale 1ns/1ps
`default_nettype none

module uart_rx
   import soc_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   input  logic  tick_1us,
   input  logic  uart_rx,     // serial line, idle high
   output logic  rx_valid,    // one clk strobe
   output byte_t rx_byte      // held until next strobe
);

   typedef logic [$clog2(BIT_US)-1:0] bit_tmr_t;

   logic     rx_meta;
   logic     rx_sync;
   logic     rx_prev;     // for falling edge detect
   logic     busy;        // frame in progress
   bit_tmr_t bit_tmr;     // us ticks to next sample point
   logic [3:0] bit_idx;   // 0 start, 1..8 data, 9 stop
   byte_t    shreg;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rx_meta  <= 1'b1;
         rx_sync  <= 1'b1;
         rx_prev  <= 1'b1;
         busy     <= 1'b0;
         bit_tmr  <= '0;
         bit_idx  <= '0;
         shreg    <= '0;
         rx_valid <= 1'b0;
         rx_byte  <= '0;
      end else begin
         rx_meta  <= uart_rx;
         rx_sync  <= rx_meta;
         rx_prev  <= rx_sync;
         rx_valid <= 1'b0;

         if (!busy) begin
            if (rx_prev && !rx_sync) begin   // start edge
               busy    <= 1'b1;
               bit_idx <= '0;
               bit_tmr <= bit_tmr_t'(BIT_US/2 - 1);   // half bit to start check
            end
         end else if (tick_1us) begin
            if (bit_tmr != '0) begin
               bit_tmr <= bit_tmr - 1'b1;
            end else begin
               bit_tmr <= bit_tmr_t'(BIT_US - 1);     // mid of next bit
               bit_idx <= bit_idx + 1'b1;
               if (bit_idx == 4'd0) begin
                  if (rx_sync) busy <= 1'b0;           // glitch, not a start bit
               end else if (bit_idx == 4'd9) begin
                  busy <= 1'b0;
                  if (rx_sync) begin                   // good stop bit
                     rx_valid <= 1'b1;
                     rx_byte  <= shreg;
                  end
               end else begin
                  shreg <= {rx_sync, shreg[7:1]};      // lsb first
               end
            end
         end
      end
   end

   a_rx_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      rx_valid |=> !rx_valid);

endmodule: uart_rx

`default_nettype wire

/* hw/debounce.sv */
// synchronizes the push-button and filters bounce using the slow tick
`timescale 1ns/1ps
`default_nettype none

module debounce
   import soc_pkg::*;
(
   input  logic clk,
   input  logic arst_n,
   input  logic tick_15us,
   input  logic key,         // raw pin, active high
   output logic key_clean
);

   typedef logic [$clog2(DEBOUNCE_TICKS)-1:0] stab_cnt_t;

   logic      key_meta;    // first sync stage
   logic      key_sync;
   stab_cnt_t stab_cnt;    // slow ticks seen with key != key_clean

   // ====================
   // synchronizer
   // ====================
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         key_meta <= 1'b0;
         key_sync <= 1'b0;
      end else begin
         key_meta <= key;
         key_sync <= key_meta;
      end
   end

   // ====================
   // stability filter
   // ====================
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         stab_cnt  <= '0;
         key_clean <= 1'b0;
      end else if (key_sync == key_clean) begin
         stab_cnt  <= '0;                    // bounce back, start over
      end else if (tick_15us) begin
         if (stab_cnt == stab_cnt_t'(DEBOUNCE_TICKS - 1)) begin
            key_clean <= key_sync;           // stable long enough
            stab_cnt  <= '0;
         end else begin
            stab_cnt  <= stab_cnt + 1'b1;
         end
      end
   end

endmodule: debounce

`default_nettype wire

/* hw/tick_gen.sv */
// free-running divider giving a 1us tick and a ~15us tick, one clk wide each
`timescale 1ns/1ps
`default_nettype none

module tick_gen
   import soc_pkg::*;
(
   input  logic clk,
   input  logic arst_n,
   output logic tick_1us,    // every CLKS_PER_US clocks
   output logic tick_15us    // every US_PER_SLOW_TICK us ticks
);

   typedef logic [$clog2(CLKS_PER_US)-1:0]      us_cnt_t;
   typedef logic [$clog2(US_PER_SLOW_TICK)-1:0] slow_cnt_t;

   us_cnt_t   us_cnt;    // clk prescaler
   slow_cnt_t slow_cnt;  // counts us ticks

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         us_cnt    <= '0;
         slow_cnt  <= '0;
         tick_1us  <= 1'b0;
         tick_15us <= 1'b0;
      end else begin
         tick_1us  <= (us_cnt == us_cnt_t'(CLKS_PER_US - 1));
         tick_15us <= 1'b0;
         if (us_cnt == us_cnt_t'(CLKS_PER_US - 1)) us_cnt <= '0;
         else                                       us_cnt <= us_cnt + 1'b1;

         // second stage advances on the registered us tick
         if (tick_1us) begin
            if (slow_cnt == slow_cnt_t'(US_PER_SLOW_TICK - 1)) begin
               slow_cnt  <= '0;
               tick_15us <= 1'b1;   // one clk after the 15th us tick
            end else begin
               slow_cnt  <= slow_cnt + 1'b1;
            end
         end
      end
   end

endmodule: tick_gen

`default_nettype wire

/* hw/soc_pkg.sv */
// shared constants, vector types, loader states and command codes; import in each module header
`default_nettype none

package soc_pkg;

   // ====================
   // timing
   // ====================
   localparam int CLKS_PER_US      = 10;   // clk cycles per 1us tick
   localparam int US_PER_SLOW_TICK = 15;   // 1us ticks per slow tick
   localparam int BIT_US           = 8;    // 125 kbaud
   localparam int DEBOUNCE_TICKS   = 4;    // slow ticks of stable key

   // ====================
   // program memory
   // ====================
   localparam int NUM_WORDS_IMEM = 1024;
   localparam int IMEM_AW        = 10;     // word address width

   typedef logic [7:0]         byte_t;      // uart byte
   typedef logic [31:0]        word_t;      // memory word
   typedef logic [IMEM_AW-1:0] imem_addr_t;
   typedef logic [1:0]         led_t;       // active low
   typedef logic [7:0]         cmd_t;

   // host commands, ascii
   localparam cmd_t CMD_WRITE  = 8'h57;    // 'W'
   localparam cmd_t CMD_READ   = 8'h52;    // 'R'
   localparam cmd_t CMD_LED    = 8'h4C;    // 'L'
   localparam cmd_t CMD_STATUS = 8'h53;    // 'S'
   // reply codes
   localparam cmd_t RSP_ACK    = 8'h06;
   localparam cmd_t RSP_NAK    = 8'h15;

   typedef enum logic [2:0] {
      IDLE,      // waiting for command byte
      ADDR_HI,
      ADDR_LO,
      DATA,      // four write data bytes, msb first
      LED_VAL,
      MEM_RD,    // read issued, waiting for rdat
      REPLY      // draining reply buffer
   } loader_state_e;

   // loader to ram request
   typedef struct packed {
      logic       we;
      logic       re;
      imem_addr_t addr;
      word_t      wdat;
   } imem_req_t;

endpackage: soc_pkg

`default_nettype wire
